//--- exec_pkg.sv
package exec_pkg;

    //////////////////////////////
    // widths

    localparam int data_w  = 64;
    localparam int alu_w   = 32;
    localparam int shcnt_w = 5;

    //////////////////////////////
    // opcodes and states

    typedef enum logic [4:0] {
        OP_AND       = 5'd0,
        OP_ADD       = 5'd1,
        OP_PENC      = 5'd2,
        OP_PASS_B    = 5'd3,
        OP_PASS_A    = 5'd4,
        OP_CLD       = 5'd5,
        OP_STD       = 5'd6,
        OP_CMPXCHG   = 5'd7,
        OP_DAA       = 5'd8,
        OP_NOT       = 5'd9,
        OP_OR        = 5'd10,
        OP_PADDW     = 5'd11,
        OP_PADDD     = 5'd12,
        OP_PACKSSWB  = 5'd13,
        OP_PACKSSDW  = 5'd14,
        OP_PUNPCKHBW = 5'd15,
        OP_PUNPCKHWD = 5'd16,
        OP_SAR       = 5'd17,
        OP_SAL       = 5'd18
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SHIFT  = 2'd1,
        FINISH = 2'd2
    } exec_state_e;

    //////////////////////////////
    // request, response, flags

    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
        logic df;
    } flags_t;

    typedef struct packed {
        alu_op_e             op;
        logic [data_w-1:0]   op1;
        logic [data_w-1:0]   op2;
        logic [data_w-1:0]   op3;
        logic [2:0]          imm_sel;
        logic                and_mask;
        logic                shift_one;
    } exec_req_t;

    typedef struct packed {
        logic [data_w-1:0] result;
        flags_t            flags;
        logic              dest_we;
    } exec_resp_t;

    // update masks, bit order cf pf af zf sf of df
    localparam flags_t fm_arith = 7'b1101110;
    localparam flags_t fm_shift = 7'b1101100;
    localparam flags_t fm_daa   = 7'b1010000;
    localparam flags_t fm_zf    = 7'b0001000;
    localparam flags_t fm_df    = 7'b0000001;

    // even parity of the low result byte
    function automatic logic even_par(input logic [7:0] b);
        return ~(^b);
    endfunction

endpackage

//--- alu_logic.sv
module alu_logic import exec_pkg::*; (
    input  exec_req_t         req,
    output logic [data_w-1:0] result,
    output flags_t            flags,
    output flags_t            fmask
);

    logic [data_w-1:0]  and_b;
    logic [shcnt_w-1:0] penc_idx;
    logic               penc_none;

    // mask option clears everything above bit 15
    assign and_b = req.and_mask ? data_w'(16'hffff) : req.op2;

    // highest set bit wins, scan from the bottom up
    always_comb begin
        penc_idx  = '0;
        penc_none = 1'b1;
        for (int i = 0; i < alu_w; i++) begin
            if (req.op1[i]) begin
                penc_idx  = shcnt_w'(i);
                penc_none = 1'b0;
            end
        end
    end

    always_comb begin
        result = '0;
        fmask  = '0;
        case (req.op)
            OP_AND: begin
                result = req.op1 & and_b;
                fmask  = fm_arith;
            end
            OP_OR: begin
                result = req.op1 | req.op2;
                fmask  = fm_arith;
            end
            OP_NOT:    result = ~req.op1;
            OP_PASS_A: result = req.op1;
            OP_PASS_B: result = req.op2;
            OP_CLD:    fmask  = fm_df;
            OP_STD: begin
                result = data_w'(1);
                fmask  = fm_df;
            end
            OP_PENC: begin
                result = data_w'(penc_idx);
                fmask  = fm_zf;
            end
            default: ;
        endcase
    end

    // only the masked bits reach EFLAGS
    assign flags = '{
        cf: 1'b0,
        pf: even_par(result[7:0]),
        af: 1'b0,
        zf: (req.op == OP_PENC) ? penc_none : (result == '0),
        sf: result[data_w-1],
        of: 1'b0,
        df: (req.op == OP_STD)
    };

endmodule

//--- alu_arith.sv
module alu_arith import exec_pkg::*; (
    input  exec_req_t         req,
    input  logic              cf_in,
    input  logic              af_in,
    output logic [data_w-1:0] result,
    output flags_t            flags,
    output flags_t            fmask,
    output logic              dest_we
);

    logic [alu_w-1:0] add_a;
    logic [alu_w-1:0] add_b;
    logic [alu_w:0]   add_sum;
    logic             add_of;
    logic [7:0]       al;
    logic [7:0]       al_lo;
    logic [7:0]       al_hi;
    logic             daa_af;
    logic             daa_cf;
    logic             cmp_eq;

    //////////////////////////////
    // add with immediate select

    assign add_a = req.op1[alu_w-1:0];

    always_comb begin
        case (req.imm_sel)
            3'd0:    add_b = req.op2[alu_w-1:0];
            3'd1:    add_b = 32'd2;
            3'd2:    add_b = 32'd4;
            3'd4:    add_b = 32'd6;
            3'd5:    add_b = 32'hffff_fffe;
            3'd6:    add_b = 32'hffff_fffc;
            default: add_b = '0;
        endcase
    end

    assign add_sum = {1'b0, add_a} + {1'b0, add_b};
    // same operand signs, different result sign
    assign add_of  = (add_a[alu_w-1] == add_b[alu_w-1]) &&
                     (add_sum[alu_w-1] != add_a[alu_w-1]);

    //////////////////////////////
    // decimal adjust of AL

    assign al     = req.op1[7:0];
    assign daa_af = (al[3:0] > 4'd9) || af_in;
    assign al_lo  = daa_af ? al + 8'h06 : al;
    // high digit test uses the AL before the low fix
    assign daa_cf = (al > 8'h99) || cf_in;
    assign al_hi  = daa_cf ? al_lo + 8'h60 : al_lo;

    assign cmp_eq = (req.op1[alu_w-1:0] == req.op3[alu_w-1:0]);

    always_comb begin
        result  = '0;
        flags   = '0;
        fmask   = '0;
        dest_we = 1'b0;
        case (req.op)
            OP_ADD: begin
                result = {{(data_w-alu_w){add_sum[alu_w-1]}}, add_sum[alu_w-1:0]};
                flags  = '{
                    cf: add_sum[alu_w],
                    pf: even_par(add_sum[7:0]),
                    af: 1'b0,
                    zf: (add_sum[alu_w-1:0] == '0),
                    sf: add_sum[alu_w-1],
                    of: add_of,
                    df: 1'b0
                };
                fmask  = fm_arith;
            end
            OP_DAA: begin
                result   = data_w'(al_hi);
                flags.cf = daa_cf;
                flags.af = daa_af;
                fmask    = fm_daa;
            end
            OP_CMPXCHG: begin
                // equal: new value goes to the destination
                result   = cmp_eq ? req.op2 : req.op1;
                flags.zf = cmp_eq;
                fmask    = fm_zf;
                dest_we  = cmp_eq;
            end
            default: ;
        endcase
    end

endmodule

//--- alu_simd.sv
module alu_simd import exec_pkg::*; (
    input  exec_req_t         req,
    output logic [data_w-1:0] result
);

    // signed word to signed byte, clamp on overflow
    function automatic logic [7:0] sat_byte(input logic [15:0] w);
        if (w[15:7] == {9{w[15]}}) begin
            return w[7:0];
        end
        return w[15] ? 8'h80 : 8'h7f;
    endfunction

    // signed dword to signed word
    function automatic logic [15:0] sat_word(input logic [31:0] d);
        if (d[31:15] == {17{d[31]}}) begin
            return d[15:0];
        end
        return d[31] ? 16'h8000 : 16'h7fff;
    endfunction

    always_comb begin
        result = '0;
        case (req.op)
            OP_PADDW: begin
                for (int i = 0; i < 4; i++) begin
                    result[16*i +: 16] = req.op1[16*i +: 16] + req.op2[16*i +: 16];
                end
            end
            OP_PADDD: begin
                for (int i = 0; i < 2; i++) begin
                    result[32*i +: 32] = req.op1[32*i +: 32] + req.op2[32*i +: 32];
                end
            end
            // op1 lanes low half, op2 lanes high half
            OP_PACKSSWB: begin
                for (int i = 0; i < 4; i++) begin
                    result[8*i +: 8]      = sat_byte(req.op1[16*i +: 16]);
                    result[32+8*i +: 8]   = sat_byte(req.op2[16*i +: 16]);
                end
            end
            OP_PACKSSDW: begin
                for (int i = 0; i < 2; i++) begin
                    result[16*i +: 16]    = sat_word(req.op1[32*i +: 32]);
                    result[32+16*i +: 16] = sat_word(req.op2[32*i +: 32]);
                end
            end
            // high halves interleaved, op1 lane first
            OP_PUNPCKHBW: begin
                for (int i = 0; i < 4; i++) begin
                    result[16*i +: 8]     = req.op1[32+8*i +: 8];
                    result[16*i+8 +: 8]   = req.op2[32+8*i +: 8];
                end
            end
            OP_PUNPCKHWD: begin
                for (int i = 0; i < 2; i++) begin
                    result[32*i +: 16]    = req.op1[32+16*i +: 16];
                    result[32*i+16 +: 16] = req.op2[32+16*i +: 16];
                end
            end
            default: ;
        endcase
    end

endmodule

//--- shift_counter.sv
module shift_counter import exec_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  logic [shcnt_w-1:0] count_in,
    input  logic               step,
    output logic               cnt_zero
);

    logic [shcnt_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= count_in;
        end else if (step) begin
            cnt <= cnt - 1'b1;
        end
    end

    // also high in the cycle whose step spends the last count
    assign cnt_zero = (cnt == '0) || (step && (cnt == shcnt_w'(1)));

    // FSM must leave SHIFT on the last step
    step_not_spent: assert property (@(posedge clk) disable iff (rst) step |-> cnt != '0);

endmodule

//--- shift_unit.sv
module shift_unit import exec_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic             step,
    input  logic             arith,
    input  logic             left,
    input  logic [alu_w-1:0] data_in,
    output logic [alu_w-1:0] shift_val,
    output logic             last_out
);

    // one bit per step
    always_ff @(posedge clk) begin
        if (load) begin
            shift_val <= data_in;
        end else if (step) begin
            if (left) begin
                shift_val <= {shift_val[alu_w-2:0], 1'b0};
            end else begin
                shift_val <= {arith & shift_val[alu_w-1], shift_val[alu_w-1:1]};
            end
        end
    end

    // bit that fell off, becomes CF
    always_ff @(posedge clk) begin
        if (rst || load) begin
            last_out <= 1'b0;
        end else if (step) begin
            last_out <= left ? shift_val[alu_w-1] : shift_val[0];
        end
    end

endmodule

//--- flag_unit.sv
module flag_unit import exec_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   finish,
    input  flags_t flags_new,
    input  flags_t fmask,
    output flags_t eflags
);

    // masked bits take the new value, the rest hold
    always_ff @(posedge clk) begin
        if (rst) begin
            eflags <= '0;
        end else if (finish) begin
            eflags <= flags_t'((eflags & ~fmask) | (flags_new & fmask));
        end
    end

endmodule

//--- exec_ctrl.sv
module exec_ctrl import exec_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic issue,
    input  logic is_shift,
    input  logic cnt_zero,
    output logic load,
    output logic step,
    output logic finish,
    output logic busy,
    output logic done
);

    exec_state_e state;
    exec_state_e state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= finish;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // zero-count shifts skip straight to FINISH
                if (issue) begin
                    state_nxt = is_shift ? SHIFT : FINISH;
                end
            end
            SHIFT: begin
                if (cnt_zero) begin
                    state_nxt = FINISH;
                end
            end
            FINISH:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign load   = (state == IDLE) && issue;
    assign step   = (state == SHIFT);
    assign finish = (state == FINISH);
    // covers the done cycle too
    assign busy   = (state != IDLE) || done;

    no_issue_busy: assert property (@(posedge clk) disable iff (rst) issue |-> !busy);
    done_one_shot: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

//--- exec_top.sv
module exec_top import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue,
    input  exec_req_t  req,
    output logic       busy,
    output logic       done,
    output exec_resp_t resp
);

    exec_req_t          req_q;
    logic [shcnt_w-1:0] count_in;
    logic               is_shift;
    logic               load;
    logic               step;
    logic               finish;
    logic               cnt_zero;
    logic [alu_w-1:0]   shift_val;
    logic               last_out;
    logic [data_w-1:0]  logic_res;
    logic [data_w-1:0]  arith_res;
    logic [data_w-1:0]  simd_res;
    logic [data_w-1:0]  sel_res;
    logic [data_w-1:0]  result_q;
    flags_t             logic_flags;
    flags_t             logic_mask;
    flags_t             arith_flags;
    flags_t             arith_mask;
    flags_t             shift_flags;
    flags_t             sel_flags;
    flags_t             sel_mask;
    flags_t             eflags;
    logic               arith_we;
    logic               we_q;

    always_ff @(posedge clk) begin
        if (issue) begin
            req_q <= req;
        end
    end

    //////////////////////////////
    // shift path

    // counter and shifter load from the request being issued
    assign count_in = req.shift_one ? shcnt_w'(1) : req.op2[shcnt_w-1:0];
    assign is_shift = ((req.op == OP_SAL) || (req.op == OP_SAR)) && (count_in != '0);

    exec_ctrl ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .is_shift (is_shift),
        .cnt_zero (cnt_zero),
        .load     (load),
        .step     (step),
        .finish   (finish),
        .busy     (busy),
        .done     (done)
    );

    shift_counter cnt_i (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .count_in (count_in),
        .step     (step),
        .cnt_zero (cnt_zero)
    );

    shift_unit shf_i (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .step      (step),
        .arith     (req_q.op == OP_SAR),
        .left      (req_q.op == OP_SAL),
        .data_in   (req.op1[alu_w-1:0]),
        .shift_val (shift_val),
        .last_out  (last_out)
    );

    assign shift_flags = '{
        cf: last_out,
        pf: even_par(shift_val[7:0]),
        af: 1'b0,
        zf: (shift_val == '0),
        sf: shift_val[alu_w-1],
        of: 1'b0,
        df: 1'b0
    };

    //////////////////////////////
    // ALU blocks and select

    alu_logic logic_i (
        .req    (req_q),
        .result (logic_res),
        .flags  (logic_flags),
        .fmask  (logic_mask)
    );

    alu_arith arith_i (
        .req     (req_q),
        .cf_in   (eflags.cf),
        .af_in   (eflags.af),
        .result  (arith_res),
        .flags   (arith_flags),
        .fmask   (arith_mask),
        .dest_we (arith_we)
    );

    alu_simd simd_i (
        .req    (req_q),
        .result (simd_res)
    );

    always_comb begin
        sel_res   = logic_res;
        sel_flags = logic_flags;
        sel_mask  = logic_mask;
        case (req_q.op)
            OP_ADD, OP_DAA, OP_CMPXCHG: begin
                sel_res   = arith_res;
                sel_flags = arith_flags;
                sel_mask  = arith_mask;
            end
            // packed ops leave EFLAGS alone
            OP_PADDW, OP_PADDD, OP_PACKSSWB, OP_PACKSSDW,
            OP_PUNPCKHBW, OP_PUNPCKHWD: begin
                sel_res   = simd_res;
                sel_flags = '0;
                sel_mask  = '0;
            end
            OP_SAL, OP_SAR: begin
                sel_res   = {{(data_w-alu_w){1'b0}}, shift_val};
                sel_flags = shift_flags;
                sel_mask  = fm_shift;
            end
            default: ;
        endcase
    end

    flag_unit flags_i (
        .clk       (clk),
        .rst       (rst),
        .finish    (finish),
        .flags_new (sel_flags),
        .fmask     (sel_mask),
        .eflags    (eflags)
    );

    // result, flags and done all move on the edge that ends FINISH
    always_ff @(posedge clk) begin
        if (finish) begin
            result_q <= sel_res;
            we_q     <= arith_we;
        end
    end

    assign resp = '{result: result_q, flags: eflags, dest_we: we_q};

endmodule

//--- tb_clock.sv
module tb_clock (
    output logic clk
);

    // free running, period 100
    initial begin
        clk = 1'b0;
    end

    always begin
        #50 clk = ~clk;
    end

endmodule

//--- exec_tb.sv
module exec_tb import exec_pkg::*; ();

    localparam int max_cases = 64;
    localparam int case_wait = 40;

    logic       clk;
    logic       rst;
    logic       issue;
    exec_req_t  req;
    logic       busy;
    logic       done;
    exec_resp_t resp;

    logic [8*16-1:0]   names      [max_cases];
    exec_req_t         case_req   [max_cases];
    logic [data_w-1:0] exp_result [max_cases];
    flags_t            exp_flags  [max_cases];
    logic              exp_we     [max_cases];

    int num_cases;
    int pass_count;
    int fail_count;
    int cycle_limit = 0;
    int cycle_count = 0;

    tb_clock clock_i (
        .clk (clk)
    );

    exec_top exec_top_i (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .resp  (resp)
    );

    //////////////////////////////
    // watchdog

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run stopped after %0d cycles with cases still pending", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // case file

    // lines that do not scan as a full case are skipped
    task automatic read_cases();
        int              fd;
        int              got;
        logic [8*256-1:0] line;
        logic [8*16-1:0]  name;
        int              op;
        logic [63:0]     op1;
        logic [63:0]     op2;
        logic [63:0]     op3;
        int              imm;
        int              msk;
        int              one;
        logic [63:0]     res;
        logic [6:0]      flg;
        int              we;
        exec_req_t       r;
        num_cases = 0;
        fd = $fopen("exec_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                got = $fgets(line, fd);
                got = $sscanf(line, "%s %d %h %h %h %d %d %d %h %b %d", name, op, op1,
                              op2, op3, imm, msk, one, res, flg, we);
                if (got == 11 && num_cases < max_cases) begin
                    r.op        = alu_op_e'(op);
                    r.op1       = op1;
                    r.op2       = op2;
                    r.op3       = op3;
                    r.imm_sel   = 3'(imm);
                    r.and_mask  = (msk != 0);
                    r.shift_one = (one != 0);
                    names[num_cases]      = name;
                    case_req[num_cases]   = r;
                    exp_result[num_cases] = res;
                    exp_flags[num_cases]  = flags_t'(flg);
                    exp_we[num_cases]     = (we != 0);
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // one issue, one response

    task automatic run_case(input int idx);
        int         count;
        int         exp_lat;
        int         waited;
        logic       ok;
        logic       busy_low;
        exec_resp_t got;
        ok    = 1'b1;
        count = 0;
        // shifts take one cycle per bit, count 0 goes straight through
        if (case_req[idx].op == OP_SAL || case_req[idx].op == OP_SAR) begin
            if (case_req[idx].shift_one) begin
                count = 1;
            end else begin
                count = int'(case_req[idx].op2[4:0]);
            end
        end
        exp_lat = 1 + count;

        @(negedge clk);
        if (busy) begin
            $display("case %0s: DUT still busy when the request was issued", names[idx]);
            ok = 1'b0;
        end
        @(posedge clk);
        issue <= 1'b1;
        req   <= case_req[idx];
        @(posedge clk);
        issue <= 1'b0;

        waited   = 0;
        busy_low = 1'b0;
        do begin
            @(negedge clk);
            waited++;
            // busy spans every cycle from the issue edge through done
            if (!busy) begin
                busy_low = 1'b1;
            end
        end while (!done && waited < case_wait);

        if (busy_low) begin
            $display("case %0s: busy went low before done", names[idx]);
            ok = 1'b0;
        end

        if (!done) begin
            $display("case %0s: done never came within %0d cycles", names[idx], case_wait);
            ok = 1'b0;
        end else begin
            got = resp;
            if (got.result !== exp_result[idx]) begin
                $display("FAIL %0s result expected %h actual %h", names[idx],
                         exp_result[idx], got.result);
                ok = 1'b0;
            end
            if (got.flags !== exp_flags[idx]) begin
                $display("FAIL %0s flags expected %b actual %b", names[idx],
                         exp_flags[idx], got.flags);
                ok = 1'b0;
            end
            if (got.dest_we !== exp_we[idx]) begin
                $display("FAIL %0s dest_we expected %b actual %b", names[idx],
                         exp_we[idx], got.dest_we);
                ok = 1'b0;
            end
            if (waited - 1 != exp_lat) begin
                $display("FAIL %0s latency expected %0d actual %0d", names[idx],
                         exp_lat, waited - 1);
                ok = 1'b0;
            end
        end

        if (ok) begin
            pass_count++;
            $display("PASS %0s", names[idx]);
        end else begin
            fail_count++;
        end
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        int seed;
        seed       = $urandom(43);
        rst        = 1'b1;
        issue      = 1'b0;
        req        = '0;
        pass_count = 0;
        fail_count = 0;
        read_cases();
        cycle_limit = case_wait * num_cases;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        if (num_cases == 0) begin
            $display("no test cases could be read from exec_cases.txt");
            fail_count++;
        end
        // flags carry over, so file order matters
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end

        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- exec_cases.txt
# name op(dec) op1 op2 op3 imm_sel and_mask shift_one result flags dest_we
# flags bit order: cf pf af zf sf of df
and_plain 0 ff00ff00ff00ff0f 0f0f0f0f0f0f0f0f 0 0 0 0 0f000f000f000f0f 0100000 0
and_mask 0 ffffffffffff0000 ffffffffffffffff 0 0 1 0 0000000000000000 0101000 0
or_sign 10 8000000000000000 0000000000000001 0 0 0 0 8000000000000001 0000100 0
not_op 9 00000000ffffff00 0 0 0 0 0 ffffffff000000ff 0000100 0
pass_a 4 0123456789abcdef fedcba9876543210 0 0 0 0 0123456789abcdef 0000100 0
pass_b 3 0123456789abcdef fedcba9876543210 0 0 0 0 fedcba9876543210 0000100 0
std_first 6 0 0 0 0 0 0 0000000000000001 0000101 0
cld_clear 5 0 0 0 0 0 0 0000000000000000 0000100 0
add_sel0 1 000000007fffffff 0000000000000001 0 0 0 0 ffffffff80000000 0100110 0
add_sel1 1 00000000fffffffe 0 0 1 0 0 0000000000000000 1101000 0
daa_cf 8 0000000000000012 0 0 0 0 0 0000000000000072 1101000 0
add_sel2 1 ffff000000000010 0 0 2 0 0 0000000000000014 0100000 0
add_sel3 1 0000000012345680 0000000000000005 0 3 0 0 0000000012345680 0000000 0
add_sel4 1 0000000000000009 0 0 4 0 0 000000000000000f 0100000 0
daa_af 8 000000000000000f 0 0 0 0 0 0000000000000015 0110000 0
add_sel5 1 0000000080000001 0 0 5 0 0 000000007fffffff 1110010 0
add_sel6 1 0000000000000001 0 0 6 0 0 fffffffffffffffd 0010100 0
add_sel7 1 00000000000000ff 0000000000000011 0 7 0 0 00000000000000ff 0110000 0
cmpx_eq 7 ffffffff00001234 aaaaaaaa55555555 0000000000001234 0 0 0 aaaaaaaa55555555 0111000 1
cmpx_ne 7 0000000000001234 aaaaaaaa55555555 0000000000001235 0 0 0 0000000000001234 0110000 0
penc_zero 2 ffffffff00000000 0 0 0 0 0 0000000000000000 0111000 0
penc_top 2 0000000180000001 0 0 0 0 0 000000000000001f 0110000 0
paddw 11 7fff0001ffff8000 0001ffff00018000 0 0 0 0 8000000000000000 0110000 0
paddd 12 ffffffff00000005 0000000200000003 0 0 0 0 0000000100000008 0110000 0
packsswb 13 ff80007fff7f0080 ffff7fff80000001 0 0 0 0 ff7f8001807f807f 0110000 0
packssdw 14 ffff7fff00008000 00001234ffffffff 0 0 0 0 1234ffff80007fff 0110000 0
punpckhbw 15 8877665544332211 ffeeddccbbaa9988 0 0 0 0 ff88ee77dd66cc55 0110000 0
punpckhwd 16 8877665544332211 ffeeddccbbaa9988 0 0 0 0 ffee8877ddcc6655 0110000 0
sal_cnt0 18 ffffffff80000001 0 0 0 0 0 0000000080000001 0010100 0
sal_one 18 00000000c0000001 0000000000000007 0 0 0 1 0000000080000002 1010100 0
sar_5 17 0000000080000010 0000000000000005 0 0 0 0 00000000fc000000 1110100 0
sal_31 18 0000000000000001 000000000000001f 0 0 0 0 0000000080000000 0110100 0
sar_31 17 0000000040000000 000000000000001f 0 0 0 0 0000000000000000 1111000 0

//--- build.f
exec_pkg.sv
alu_logic.sv
alu_arith.sv
alu_simd.sv
shift_counter.sv
shift_unit.sv
flag_unit.sv
exec_ctrl.sv
exec_top.sv
tb_clock.sv
exec_tb.sv
